//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module keccak_ctrl_tb -Mdir obj_dir -f sources.f
	@out="$$(./obj_dir/Vkeccak_ctrl_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- design/block_tracker.sv
// ****************************************
// block tracker
// holds header and length fields, counts
// message words left and flags a pad block
// ****************************************
`timescale 1ns/1ps

module block_tracker (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [2:0]                             state,
  input  logic [keccak_ctrl_pkg::word_width-1:0] din,
  input  logic                                   din_valid,
  input  logic                                   din_ready,
  input  logic                                   absorb_data,
  output logic                                   sel_256,
  output logic [keccak_ctrl_pkg::idx_width-1:0]  rate_words,
  output logic [keccak_ctrl_pkg::rate_width-1:0] len_bits,
  output logic [keccak_ctrl_pkg::idx_width-1:0]  words_left,
  output logic                                   eof,
  output logic                                   extra_pad
);

  keccak_ctrl_pkg::cmd_word_u             cmd;
  logic                                   hdr_fire;
  logic                                   len_fire;
  logic                                   word_taken;
  logic [keccak_ctrl_pkg::rate_width-1:0] rate_bits;
  logic [keccak_ctrl_pkg::rate_width-1:0] pad_limit;
  logic [keccak_ctrl_pkg::idx_width-1:0]  len_words;

  assign cmd = din;

  assign hdr_fire   = (state == keccak_ctrl_pkg::st_header) && din_valid && din_ready;
  assign len_fire   = (state == keccak_ctrl_pkg::st_length) && din_valid && din_ready;
  assign word_taken = absorb_data && din_ready;

  assign rate_words = sel_256 ? keccak_ctrl_pkg::rate_256_words
                              : keccak_ctrl_pkg::rate_128_words;
  assign rate_bits  = {rate_words,
                       {(keccak_ctrl_pkg::rate_width - keccak_ctrl_pkg::idx_width){1'b0}}};

  // suffix plus the final pad one must fit below the rate
  assign pad_limit = rate_bits - keccak_ctrl_pkg::suffix_bits - 1'b1;

  // length rounded up to whole words
  assign len_words =
    cmd.len.len_bits[keccak_ctrl_pkg::rate_width-1 -: keccak_ctrl_pkg::idx_width] +
    (|cmd.len.len_bits[keccak_ctrl_pkg::rate_width-keccak_ctrl_pkg::idx_width-1:0]);

  always_ff @(posedge clk)
  begin
    if (rst)
      sel_256 <= 1'b0;
    else if (hdr_fire)
      sel_256 <= cmd.hdr.sel_256;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      eof      <= 1'b0;
      len_bits <= '0;
    end
    else if (len_fire)
    begin
      eof      <= cmd.len.eof;
      len_bits <= cmd.len.len_bits;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      words_left <= '0;
    else if (len_fire)
      words_left <= len_words;
    else if (word_taken)
      words_left <= words_left - 1'b1;
  end

  // cleared once the pad block is under way
  always_ff @(posedge clk)
  begin
    if (rst)
      extra_pad <= 1'b0;
    else if (len_fire)
      extra_pad <= (cmd.len.len_bits > pad_limit);
    else if (state == keccak_ctrl_pkg::st_pad_block)
      extra_pad <= 1'b0;
  end

endmodule

//--- design/ctrl_fsm.sv
// ****************************************
// phase state machine
// sequences header, length, absorb,
// permutation and squeeze phases
// ****************************************
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  din_valid,
  input  logic                                  dout_ready,
  input  logic [keccak_ctrl_pkg::idx_width-1:0] rate_words,
  input  logic [keccak_ctrl_pkg::idx_width-1:0] words_left,
  input  logic                                  eof,
  input  logic                                  extra_pad,
  input  logic                                  last_word,
  output logic [2:0]                            state,
  output logic [keccak_ctrl_pkg::idx_width-1:0] word_idx,
  output logic                                  din_ready,
  output logic                                  dout_valid,
  output logic                                  absorb_data,
  output logic                                  computation_en,
  output logic                                  squeeze_output,
  output logic                                  bof,
  output logic                                  reset_ram
);

  logic [2:0]                            state_next;
  logic                                  cnt_inc;
  logic                                  block_end;
  logic                                  round_end;
  logic [keccak_ctrl_pkg::idx_width-1:0] last_idx;

  assign last_idx  = rate_words - 1'b1;
  assign block_end = (word_idx == last_idx);
  assign round_end = (word_idx == keccak_ctrl_pkg::round_count - 1'b1);

  always_comb
  begin
    state_next     = state;
    cnt_inc        = 1'b0;
    din_ready      = 1'b0;
    dout_valid     = 1'b0;
    absorb_data    = 1'b0;
    computation_en = 1'b0;
    squeeze_output = 1'b0;
    reset_ram      = 1'b0;
    case (state)
      keccak_ctrl_pkg::st_header:
      begin
        din_ready = 1'b1;
        reset_ram = 1'b1;
        if (din_valid)
          state_next = keccak_ctrl_pkg::st_length;
      end
      keccak_ctrl_pkg::st_length:
      begin
        din_ready = 1'b1;
        if (din_valid)
          state_next = keccak_ctrl_pkg::st_absorb;
      end
      keccak_ctrl_pkg::st_absorb:
      begin
        din_ready = (words_left != '0);
        // once the message runs out, zero words go in without waiting
        absorb_data = din_valid || (words_left == '0);
        if (absorb_data && block_end)
          state_next = keccak_ctrl_pkg::st_process;
        else if (absorb_data)
          cnt_inc = 1'b1;
      end
      keccak_ctrl_pkg::st_pad_block:
      begin
        absorb_data = 1'b1;
        if (block_end)
          state_next = keccak_ctrl_pkg::st_process;
        else
          cnt_inc = 1'b1;
      end
      keccak_ctrl_pkg::st_process:
      begin
        computation_en = 1'b1;
        cnt_inc        = 1'b1;
        if (round_end && !eof)
          state_next = keccak_ctrl_pkg::st_length;
        else if (round_end && extra_pad)
          state_next = keccak_ctrl_pkg::st_pad_block;
        else if (round_end)
          state_next = keccak_ctrl_pkg::st_squeeze;
      end
      keccak_ctrl_pkg::st_squeeze:
      begin
        dout_valid     = 1'b1;
        squeeze_output = dout_ready;
        if (dout_ready && last_word)
          state_next = keccak_ctrl_pkg::st_header;
        else if (dout_ready && block_end)
          // rate exhausted with words still owed
          state_next = keccak_ctrl_pkg::st_process;
        else if (dout_ready)
          cnt_inc = 1'b1;
      end
      default:
      begin
        state_next = keccak_ctrl_pkg::st_header;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= keccak_ctrl_pkg::st_header;
    else
      state <= state_next;
  end

  // shared counter restarts on every phase change
  always_ff @(posedge clk)
  begin
    if (rst)
      word_idx <= '0;
    else if (state_next != state)
      word_idx <= '0;
    else if (cnt_inc)
      word_idx <= word_idx + 1'b1;
  end

  // first block flag, dropped after the first permutation
  always_ff @(posedge clk)
  begin
    if (rst)
      bof <= 1'b0;
    else if (state == keccak_ctrl_pkg::st_header)
      bof <= 1'b1;
    else if ((state == keccak_ctrl_pkg::st_process) && round_end)
      bof <= 1'b0;
  end

endmodule

//--- design/keccak_ctrl.sv
// ****************************************
// keccak control path top level
// sequencer, block tracker, padder and
// squeeze counter for a 32-slice core
// ****************************************
`timescale 1ns/1ps

module keccak_ctrl (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   din_valid,
  output logic                                   din_ready,
  input  logic [keccak_ctrl_pkg::word_width-1:0] din,
  output logic                                   dout_valid,
  input  logic                                   dout_ready,
  output logic [keccak_ctrl_pkg::idx_width-1:0]  word_idx,
  output logic [keccak_ctrl_pkg::word_width-1:0] din_padded,
  output logic                                   absorb_data,
  output logic                                   computation_en,
  output logic                                   squeeze_output,
  output logic                                   bof,
  output logic                                   reset_ram,
  output logic                                   sel_256
);

  logic [2:0]                             state;
  logic [keccak_ctrl_pkg::idx_width-1:0]  rate_words;
  logic [keccak_ctrl_pkg::idx_width-1:0]  words_left;
  logic [keccak_ctrl_pkg::rate_width-1:0] len_bits;
  logic                                   eof;
  logic                                   extra_pad;
  logic                                   last_word;

  ctrl_fsm fsm_inst (
    .clk            (clk),
    .rst            (rst),
    .din_valid      (din_valid),
    .dout_ready     (dout_ready),
    .rate_words     (rate_words),
    .words_left     (words_left),
    .eof            (eof),
    .extra_pad      (extra_pad),
    .last_word      (last_word),
    .state          (state),
    .word_idx       (word_idx),
    .din_ready      (din_ready),
    .dout_valid     (dout_valid),
    .absorb_data    (absorb_data),
    .computation_en (computation_en),
    .squeeze_output (squeeze_output),
    .bof            (bof),
    .reset_ram      (reset_ram)
  );

  block_tracker block_inst (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .din         (din),
    .din_valid   (din_valid),
    .din_ready   (din_ready),
    .absorb_data (absorb_data),
    .sel_256     (sel_256),
    .rate_words  (rate_words),
    .len_bits    (len_bits),
    .words_left  (words_left),
    .eof         (eof),
    .extra_pad   (extra_pad)
  );

  pad_gen pad_inst (
    .state      (state),
    .word_idx   (word_idx),
    .din        (din),
    .din_ready  (din_ready),
    .len_bits   (len_bits),
    .eof        (eof),
    .extra_pad  (extra_pad),
    .rate_words (rate_words),
    .din_padded (din_padded)
  );

  squeeze_tracker squeeze_inst (
    .clk            (clk),
    .rst            (rst),
    .state          (state),
    .din            (din),
    .din_valid      (din_valid),
    .din_ready      (din_ready),
    .squeeze_output (squeeze_output),
    .last_word      (last_word)
  );

endmodule

//--- design/keccak_ctrl_pkg.sv
// ****************************************
// keccak control package
// widths, SHAKE rates, phase codes and the
// two-view command word
// ****************************************

package keccak_ctrl_pkg;

  // datapath word, one lane slice per cycle
  localparam int word_width = 32;

  // word counter and bit-length widths
  localparam int idx_width  = 6;
  localparam int rate_width = 11;
  localparam int req_width  = 30;

  // block size in words: 1344 and 1088 bits
  localparam logic [idx_width-1:0] rate_128_words = 6'd42;
  localparam logic [idx_width-1:0] rate_256_words = 6'd34;

  // permutation length in cycles
  localparam logic [idx_width-1:0] round_count = 6'd24;

  // SHAKE suffix 1111 plus first pad one
  localparam logic [rate_width-1:0] suffix_bits = 11'd5;

  // phase codes
  localparam logic [2:0] st_header    = 3'd0;
  localparam logic [2:0] st_length    = 3'd1;
  localparam logic [2:0] st_absorb    = 3'd2;
  localparam logic [2:0] st_pad_block = 3'd3;
  localparam logic [2:0] st_process   = 3'd4;
  localparam logic [2:0] st_squeeze   = 3'd5;

  // one input word, read as command header or as block length
  typedef union packed {
    struct packed {
      logic                 reserved;
      logic                 sel_256;
      logic [req_width-1:0] req_words;
    } hdr;
    struct packed {
      logic                                eof;
      logic [word_width-rate_width-2:0]    unused;
      logic [rate_width-1:0]               len_bits;
    } len;
  } cmd_word_u;

endpackage

//--- design/pad_gen.sv
// ****************************************
// padder
// masks message data and applies the SHAKE
// suffix and pad10*1 bits per word
// ****************************************
`timescale 1ns/1ps

module pad_gen (
  input  logic [2:0]                             state,
  input  logic [keccak_ctrl_pkg::idx_width-1:0]  word_idx,
  input  logic [keccak_ctrl_pkg::word_width-1:0] din,
  input  logic                                   din_ready,
  input  logic [keccak_ctrl_pkg::rate_width-1:0] len_bits,
  input  logic                                   eof,
  input  logic                                   extra_pad,
  input  logic [keccak_ctrl_pkg::idx_width-1:0]  rate_words,
  output logic [keccak_ctrl_pkg::word_width-1:0] din_padded
);

  logic [keccak_ctrl_pkg::rate_width-1:0] rate_bits;
  logic [keccak_ctrl_pkg::rate_width-1:0] last_bit;
  logic [keccak_ctrl_pkg::rate_width:0]   suf_end;
  logic [keccak_ctrl_pkg::idx_width-1:0]  last_idx;

  assign rate_bits = {rate_words,
                      {(keccak_ctrl_pkg::rate_width - keccak_ctrl_pkg::idx_width){1'b0}}};
  assign last_bit  = rate_bits - 1'b1;
  assign suf_end   = {1'b0, len_bits} + keccak_ctrl_pkg::suffix_bits;
  assign last_idx  = rate_words - 1'b1;

  always_comb
  begin
    logic [keccak_ctrl_pkg::rate_width-1:0] pos;
    din_padded = '0;
    pos        = '0;
    if (state == keccak_ctrl_pkg::st_absorb)
    begin
      if (din_ready)
        din_padded = din;
      for (int i = 0; i < keccak_ctrl_pkg::word_width; i++)
      begin
        // absolute bit position inside the block
        pos = {word_idx, i[keccak_ctrl_pkg::rate_width-keccak_ctrl_pkg::idx_width-1:0]};
        if (pos >= len_bits)
          din_padded[i] = 1'b0;
        // suffix ones, clipped at the rate boundary
        if (eof && (pos >= len_bits) && ({1'b0, pos} < suf_end))
          din_padded[i] = 1'b1;
        if (eof && !extra_pad && (pos == last_bit))
          din_padded[i] = 1'b1;
      end
    end
    else if (state == keccak_ctrl_pkg::st_pad_block)
    begin
      // only the closing pad one
      if (word_idx == last_idx)
        din_padded[keccak_ctrl_pkg::word_width-1] = 1'b1;
    end
  end

endmodule

//--- design/squeeze_tracker.sv
// ****************************************
// squeeze tracker
// counts requested output words down and
// flags the last one
// ****************************************
`timescale 1ns/1ps

module squeeze_tracker (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [2:0]                             state,
  input  logic [keccak_ctrl_pkg::word_width-1:0] din,
  input  logic                                   din_valid,
  input  logic                                   din_ready,
  input  logic                                   squeeze_output,
  output logic                                   last_word
);

  keccak_ctrl_pkg::cmd_word_u            cmd;
  logic                                  hdr_fire;
  logic [keccak_ctrl_pkg::req_width-1:0] req_load;
  logic [keccak_ctrl_pkg::req_width-1:0] remaining;

  assign cmd      = din;
  assign hdr_fire = (state == keccak_ctrl_pkg::st_header) && din_valid && din_ready;

  // a zero request still yields one word
  assign req_load = (cmd.hdr.req_words == '0)
                    ? {{(keccak_ctrl_pkg::req_width-1){1'b0}}, 1'b1}
                    : cmd.hdr.req_words;

  always_ff @(posedge clk)
  begin
    if (rst)
      remaining <= '0;
    else if (hdr_fire)
      remaining <= req_load;
    else if (squeeze_output)
      remaining <= remaining - 1'b1;
  end

  assign last_word = (remaining[keccak_ctrl_pkg::req_width-1:1] == '0) && remaining[0];

endmodule

//--- sources.f
design/keccak_ctrl_pkg.sv
design/ctrl_fsm.sv
design/block_tracker.sv
design/pad_gen.sv
design/squeeze_tracker.sv
design/keccak_ctrl.sv
verification/keccak_ctrl_sva.sv
verification/keccak_ctrl_tb.sv

//--- verification/keccak_ctrl_sva.sv
// ****************************************
// keccak control assertions
// handshake and phase rules on the
// control path top level
// ****************************************
`timescale 1ns/1ps

module keccak_ctrl_sva (
  input logic                                  clk,
  input logic                                  rst,
  input logic [2:0]                            state,
  input logic [keccak_ctrl_pkg::idx_width-1:0] words_left,
  input logic                                  din_valid,
  input logic                                  din_ready,
  input logic                                  dout_valid,
  input logic                                  computation_en,
  input logic                                  bof
);

  int assert_fails = 0;

  // permutation owns the datapath alone
  comp_alone: assert property (@(posedge clk) disable iff (rst)
    computation_en |-> (!din_ready && !dout_valid))
    else
    begin
      assert_fails = assert_fails + 1;
      $error("computation_en overlaps a handshake");
    end

  // input side keeps offering until a word arrives
  ready_held: assert property (@(posedge clk) disable iff (rst)
    ((state == keccak_ctrl_pkg::st_absorb) && (words_left != '0) && !din_valid)
    |=> din_ready)
    else
    begin
      assert_fails = assert_fails + 1;
      $error("din_ready dropped before din_valid");
    end

  no_bof_squeeze: assert property (@(posedge clk) disable iff (rst)
    (state == keccak_ctrl_pkg::st_squeeze) |-> !bof)
    else
    begin
      assert_fails = assert_fails + 1;
      $error("bof high during squeeze");
    end

endmodule

bind keccak_ctrl keccak_ctrl_sva sva_inst (.*);

//--- verification/keccak_ctrl_tb.sv
// ****************************************
// keccak control testbench
// drives SHAKE messages, stands in for the
// datapath and checks the control outputs
// ****************************************
`timescale 1ns/1ps

module keccak_ctrl_tb;

  localparam int timeout_cycles = 3000;

  logic                                   clk;
  logic                                   rst;
  logic                                   din_valid;
  logic                                   din_ready;
  logic [keccak_ctrl_pkg::word_width-1:0] din;
  logic                                   dout_valid;
  logic                                   dout_ready;
  logic [keccak_ctrl_pkg::idx_width-1:0]  word_idx;
  logic [keccak_ctrl_pkg::word_width-1:0] din_padded;
  logic                                   absorb_data;
  logic                                   computation_en;
  logic                                   squeeze_output;
  logic                                   bof;
  logic                                   reset_ram;
  logic                                   sel_256;

  integer                                 seed;
  logic [keccak_ctrl_pkg::word_width-1:0] msg [0:41];
  // current block, set by stimulus before its length word
  int blk_len;
  bit blk_eof;
  bit blk_extra;
  int blk_cnt;
  int rate;
  // per-message counters kept by the compare process
  int abs_total;
  int sq_cnt;
  int perm_cnt;
  int run_len;
  bit comp_prev;

  keccak_ctrl keccak_ctrl_inst (.*);

  always #4 clk = ~clk;

  task automatic report_error(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    $display("TEST FAIL");
    $fatal(1, "mismatch");
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out waiting for %s at %0t ns", what, $time);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic check_word(input string what,
                            input logic [keccak_ctrl_pkg::word_width-1:0] got,
                            input logic [keccak_ctrl_pkg::word_width-1:0] exp);
    if (got !== exp)
      report_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_count(input string what,
                             input logic [keccak_ctrl_pkg::req_width-1:0] got,
                             input logic [keccak_ctrl_pkg::req_width-1:0] exp);
    if (got !== exp)
      report_error($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      report_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // expected absorbed word: masked data, SHAKE suffix, closing pad one
  function automatic logic [keccak_ctrl_pkg::word_width-1:0] expected_padded(
    input logic [keccak_ctrl_pkg::word_width-1:0] data,
    input int idx,
    input int len,
    input bit eof,
    input int rate_w,
    input bit extra,
    input bit pad_block);
    logic [keccak_ctrl_pkg::word_width-1:0] res;
    int pos;
    res = '0;
    for (int i = 0; i < keccak_ctrl_pkg::word_width; i++)
    begin
      pos = idx * keccak_ctrl_pkg::word_width + i;
      if (pad_block)
        res[i] = (pos == rate_w * keccak_ctrl_pkg::word_width - 1);
      else
      begin
        res[i] = (pos < len) ? data[i] : 1'b0;
        if (eof && (pos >= len) && (pos < len + keccak_ctrl_pkg::suffix_bits))
          res[i] = 1'b1;
        if (eof && !extra && (pos == rate_w * keccak_ctrl_pkg::word_width - 1))
          res[i] = 1'b1;
      end
    end
    return res;
  endfunction

  // compare process, sampled on every rising edge
  always @(posedge clk)
  begin
    int blk_idx;
    bit pad_phase;
    if (!rst)
    begin
      if (absorb_data)
      begin
        pad_phase = (blk_cnt >= rate);
        blk_idx   = blk_cnt % rate;
        check_count("absorb word_idx", word_idx, blk_idx);
        check_word("din_padded", din_padded, expected_padded(msg[blk_idx], blk_idx,
                   blk_len, blk_eof, rate, blk_extra, pad_phase));
        blk_cnt++;
        abs_total++;
      end
      if (computation_en)
      begin
        if (!comp_prev)
        begin
          perm_cnt++;
          // a squeeze permutation only after a whole rate of output
          check_count("output words before permutation", sq_cnt % rate, 0);
        end
        check_bit("bof in permutation", bof, perm_cnt == 1);
        run_len++;
      end
      else if (comp_prev)
      begin
        check_count("permutation cycles", run_len, keccak_ctrl_pkg::round_count);
        run_len = 0;
      end
      comp_prev = computation_en;
      if (dout_valid)
      begin
        check_bit("squeeze_output", squeeze_output, dout_ready);
        check_word("din_padded in squeeze", din_padded, '0);
        if (dout_ready)
        begin
          check_count("squeeze word_idx", word_idx, sq_cnt % rate);
          sq_cnt++;
        end
      end
    end
  end

  task automatic wait_ready(input string what);
    int t;
    for (t = 0; t < timeout_cycles; t++)
    begin
      @(negedge clk);
      din_valid = 1'b0;
      if (din_ready)
        break;
    end
    if (t == timeout_cycles)
      fail_timeout(what);
  endtask

  // word transfers on the rising edge after the last drive
  task automatic send_word(input logic [keccak_ctrl_pkg::word_width-1:0] word, input bit stall);
    int t;
    logic [31:0] r;
    for (t = 0; t < timeout_cycles; t++)
    begin
      @(negedge clk);
      r = $random(seed);
      if (stall && (r[1:0] == 2'b00))
        din_valid = 1'b0;
      else
      begin
        din_valid = 1'b1;
        din       = word;
        if (din_ready)
          break;
      end
    end
    if (t == timeout_cycles)
      fail_timeout("din_ready");
  endtask

  task automatic start_message(input bit sel, input int req);
    keccak_ctrl_pkg::cmd_word_u w;
    w               = '0;
    w.hdr.sel_256   = sel;
    w.hdr.req_words = req;
    rate      = sel ? keccak_ctrl_pkg::rate_256_words : keccak_ctrl_pkg::rate_128_words;
    abs_total = 0;
    sq_cnt    = 0;
    perm_cnt  = 0;
    send_word(w, 1'b0);
  endtask

  task automatic send_block(input int len, input bit eof, input bit stall);
    keccak_ctrl_pkg::cmd_word_u w;
    int n;
    wait_ready("length slot");
    for (int i = 0; i < rate; i++)
      msg[i] = $random(seed);
    blk_len   = len;
    blk_eof   = eof;
    blk_extra = (len > rate * keccak_ctrl_pkg::word_width - keccak_ctrl_pkg::suffix_bits - 1);
    blk_cnt   = 0;
    w              = '0;
    w.len.eof      = eof;
    w.len.len_bits = len;
    send_word(w, 1'b0);
    n = (len + keccak_ctrl_pkg::word_width - 1) / keccak_ctrl_pkg::word_width;
    for (int i = 0; i < n; i++)
      send_word(msg[i], stall);
    @(negedge clk);
    din_valid = 1'b0;
  endtask

  task automatic collect_output(input int req, input bit gaps, input int exp_abs,
                                input int exp_perm);
    int t;
    int want;
    logic [31:0] r;
    // zero request still gives one word
    want = (req == 0) ? 1 : req;
    for (t = 0; t < timeout_cycles; t++)
    begin
      @(negedge clk);
      if (sq_cnt == want)
        break;
      r          = $random(seed);
      dout_ready = gaps ? r[0] : 1'b1;
    end
    dout_ready = 1'b0;
    if (t == timeout_cycles)
      fail_timeout("squeeze words");
    check_bit("sel_256", sel_256, rate == keccak_ctrl_pkg::rate_256_words);
    check_count("absorb pulses", abs_total, exp_abs);
    check_count("permutations", perm_cnt, exp_perm);
    check_bit("dout_valid after squeeze", dout_valid, 1'b0);
    check_bit("din_ready after squeeze", din_ready, 1'b1);
  endtask

  initial
  begin
    seed       = 10720;
    clk        = 1'b0;
    rst        = 1'b1;
    din_valid  = 1'b0;
    din        = '0;
    dout_ready = 1'b0;
    rate       = keccak_ctrl_pkg::rate_128_words;
    blk_len    = 0;
    blk_eof    = 1'b0;
    blk_extra  = 1'b0;
    blk_cnt    = 0;
    abs_total  = 0;
    sq_cnt     = 0;
    perm_cnt   = 0;
    run_len    = 0;
    comp_prev  = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    // idle outputs in the header phase
    check_bit("din_ready at reset", din_ready, 1'b1);
    check_bit("reset_ram at reset", reset_ram, 1'b1);
    check_bit("dout_valid at reset", dout_valid, 1'b0);
    check_bit("absorb_data at reset", absorb_data, 1'b0);
    check_bit("computation_en at reset", computation_en, 1'b0);
    check_bit("squeeze_output at reset", squeeze_output, 1'b0);
    check_bit("bof at reset", bof, 1'b0);
    check_bit("sel_256 at reset", sel_256, 1'b0);
    rst = 1'b0;

    // SHAKE128, one short block
    start_message(1'b0, 4);
    send_block(100, 1'b1, 1'b0);
    collect_output(4, 1'b0, 42, 1);

    // SHAKE256, suffix spills into a pad block
    start_message(1'b1, 8);
    send_block(1085, 1'b1, 1'b0);
    collect_output(8, 1'b0, 68, 2);

    // two blocks, bof only on the first
    start_message(1'b0, 3);
    send_block(1344, 1'b0, 1'b0);
    send_block(200, 1'b1, 1'b0);
    collect_output(3, 1'b0, 84, 2);

    // more than one rate of output with back-pressure
    start_message(1'b0, 50);
    send_block(64, 1'b1, 1'b0);
    collect_output(50, 1'b1, 42, 2);

    // input stalls during absorb
    start_message(1'b0, 0);
    send_block(600, 1'b1, 1'b1);
    collect_output(0, 1'b0, 42, 1);

    if (keccak_ctrl_inst.sva_inst.assert_fails != 0)
    begin
      $display("bound assertions reported %0d failures",
               keccak_ctrl_inst.sva_inst.assert_fails);
      $display("TEST FAIL");
      $fatal(1, "assertion failures");
    end
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
